/* src/decode_pkg.sv */
// shared widths, opcode and field-location enums, request and decoded field structs
package decode_pkg;

    // instruction bytes carried with each request
    localparam int insn_bytes = 3;

    typedef enum logic [4:0] {
        OP_NONE              = 5'd0,
        MOV_REG_TO_RM        = 5'd1,
        MOV_IMM_TO_REG_SHORT = 5'd2,
        MOV_RM_TO_SREG       = 5'd3,
        MOVSX                = 5'd4,
        ADD_IMM_TO_RM        = 5'd5,
        IMUL_RM_IMM_TO_REG   = 5'd6,
        NOT_RM               = 5'd7,
        INC_REG              = 5'd8,
        PUSH_REG_SHORT       = 5'd9,
        PUSH_SREG_2          = 5'd10,
        BT_RM_WITH_REG       = 5'd11,
        SETE                 = 5'd12,
        MOV_CR_FROM_REG      = 5'd13,
        PREFIX_OPERAND_SIZE  = 5'd14,
        PREFIX_BUS_LOCK      = 5'd15,
        PREFIX_SEG_CS        = 5'd16,
        PREFIX_SEG_FS        = 5'd17,
        LEA                  = 5'd18,
        NOP                  = 5'd19
    } op_e;

    // field positions are named byte_bit(s)
    typedef enum logic [1:0] {W_NONE, W_AT_0_0, W_AT_0_3, W_AT_1_0} w_loc_e;

    typedef enum logic [2:0] {
        GREG_NONE, GREG_AT_0_2_0, GREG_AT_1_5_3, GREG_AT_2_5_3, GREG_AT_2_2_0
    } greg_loc_e;

    typedef enum logic [1:0] {SREG_NONE, SREG3_AT_1_5_3, SREG2_AT_1_4_3} sreg_loc_e;

    typedef enum logic [1:0] {MODRM_NONE, MODRM_AT_1, MODRM_AT_2} modrm_loc_e;

    typedef struct packed {
        logic       s_at_0_1;
        w_loc_e     w_loc;
        greg_loc_e  greg_loc;
        sreg_loc_e  sreg_loc;
        modrm_loc_e modrm_loc;
    } field_loc_t;

    // byte 0 sits in the top byte
    typedef logic [0:insn_bytes-1][7:0] insn_t;

    typedef struct packed {
        op_e   opcode;
        insn_t insn;
    } decode_request_t;

    typedef struct packed {
        logic has_s;
        logic s;
        logic has_w;
        logic w;
    } width_sign_t;

    typedef struct packed {
        logic       has_greg;
        logic [2:0] greg;
        logic       has_sreg;
        logic [2:0] sreg;
    } reg_fields_t;

    typedef struct packed {
        logic       has_mod_rm;
        logic [1:0] mod;
        logic [2:0] rm;
    } modrm_fields_t;

    typedef struct packed {
        logic is_prefix;
        logic is_prefix_segment;
    } prefix_flags_t;

    typedef struct packed {
        width_sign_t   width_sign;
        reg_fields_t   reg_fields;
        modrm_fields_t modrm;
        prefix_flags_t prefix;
    } decoded_fields_t;

    typedef enum logic [1:0] {DC_IDLE, DC_DECODE, DC_ACK} dc_state_e;

endpackage

/* src/opcode_locator.sv */
// opcode to field-location table and prefix flag decode
`timescale 1ns/1ps

module opcode_locator (
    input  decode_pkg::op_e           opcode,
    output decode_pkg::field_loc_t    loc,
    output decode_pkg::prefix_flags_t prefix
);

    always_comb begin
        loc.s_at_0_1  = 1'b0;
        loc.w_loc     = decode_pkg::W_NONE;
        loc.greg_loc  = decode_pkg::GREG_NONE;
        loc.sreg_loc  = decode_pkg::SREG_NONE;
        loc.modrm_loc = decode_pkg::MODRM_NONE;

        case (opcode)
            decode_pkg::MOV_REG_TO_RM: begin
                loc.w_loc     = decode_pkg::W_AT_0_0;
                loc.greg_loc  = decode_pkg::GREG_AT_1_5_3;
                loc.modrm_loc = decode_pkg::MODRM_AT_1;
            end
            decode_pkg::MOV_IMM_TO_REG_SHORT: begin
                loc.w_loc    = decode_pkg::W_AT_0_3;
                loc.greg_loc = decode_pkg::GREG_AT_0_2_0;
            end
            decode_pkg::MOV_RM_TO_SREG: begin
                loc.sreg_loc  = decode_pkg::SREG3_AT_1_5_3;
                loc.modrm_loc = decode_pkg::MODRM_AT_1;
            end
            // 0f-escaped, so reg and modrm move one byte along
            decode_pkg::MOVSX: begin
                loc.w_loc     = decode_pkg::W_AT_1_0;
                loc.greg_loc  = decode_pkg::GREG_AT_2_5_3;
                loc.modrm_loc = decode_pkg::MODRM_AT_2;
            end
            decode_pkg::ADD_IMM_TO_RM: begin
                loc.s_at_0_1  = 1'b1;
                loc.w_loc     = decode_pkg::W_AT_0_0;
                loc.modrm_loc = decode_pkg::MODRM_AT_1;
            end
            decode_pkg::IMUL_RM_IMM_TO_REG: begin
                loc.s_at_0_1  = 1'b1;
                loc.modrm_loc = decode_pkg::MODRM_AT_1;
            end
            decode_pkg::NOT_RM: begin
                loc.w_loc     = decode_pkg::W_AT_0_0;
                loc.modrm_loc = decode_pkg::MODRM_AT_1;
            end
            decode_pkg::INC_REG,
            decode_pkg::PUSH_REG_SHORT: begin
                loc.greg_loc = decode_pkg::GREG_AT_0_2_0;
            end
            decode_pkg::PUSH_SREG_2: begin
                loc.sreg_loc = decode_pkg::SREG2_AT_1_4_3;
            end
            decode_pkg::BT_RM_WITH_REG: begin
                loc.greg_loc  = decode_pkg::GREG_AT_2_5_3;
                loc.modrm_loc = decode_pkg::MODRM_AT_2;
            end
            decode_pkg::SETE: begin
                loc.modrm_loc = decode_pkg::MODRM_AT_2;
            end
            // control register move keeps the gpr in the low bits
            decode_pkg::MOV_CR_FROM_REG: begin
                loc.greg_loc = decode_pkg::GREG_AT_2_2_0;
            end
            decode_pkg::LEA: begin
                loc.modrm_loc = decode_pkg::MODRM_AT_1;
            end
            default: begin
            end
        endcase
    end

    // segment overrides count as prefixes too
    assign prefix.is_prefix_segment = (opcode == decode_pkg::PREFIX_SEG_CS) ||
                                      (opcode == decode_pkg::PREFIX_SEG_FS);
    assign prefix.is_prefix = prefix.is_prefix_segment ||
                              (opcode == decode_pkg::PREFIX_OPERAND_SIZE) ||
                              (opcode == decode_pkg::PREFIX_BUS_LOCK);

endmodule

/* src/width_sign_extractor.sv */
// sign-extend and width bit selection
`timescale 1ns/1ps

module width_sign_extractor (
    input  decode_pkg::insn_t       insn,
    input  logic                    s_at_0_1,
    input  decode_pkg::w_loc_e      w_loc,
    output decode_pkg::width_sign_t width_sign
);

    assign width_sign.has_s = s_at_0_1;
    assign width_sign.s     = s_at_0_1 & insn[0][1];

    always_comb begin
        width_sign.has_w = 1'b1;
        case (w_loc)
            decode_pkg::W_AT_0_0: width_sign.w = insn[0][0];
            // short form mov imm keeps w above the register bits
            decode_pkg::W_AT_0_3: width_sign.w = insn[0][3];
            decode_pkg::W_AT_1_0: width_sign.w = insn[1][0];
            default: begin
                width_sign.has_w = 1'b0;
                width_sign.w     = 1'b0;
            end
        endcase
    end

endmodule

/* src/reg_field_extractor.sv */
// general register and segment register field selection
`timescale 1ns/1ps

module reg_field_extractor (
    input  decode_pkg::insn_t       insn,
    input  decode_pkg::greg_loc_e   greg_loc,
    input  decode_pkg::sreg_loc_e   sreg_loc,
    output decode_pkg::reg_fields_t reg_fields
);

    always_comb begin
        reg_fields.has_greg = 1'b1;
        case (greg_loc)
            decode_pkg::GREG_AT_0_2_0: reg_fields.greg = insn[0][2:0];
            decode_pkg::GREG_AT_1_5_3: reg_fields.greg = insn[1][5:3];
            decode_pkg::GREG_AT_2_5_3: reg_fields.greg = insn[2][5:3];
            decode_pkg::GREG_AT_2_2_0: reg_fields.greg = insn[2][2:0];
            default: begin
                reg_fields.has_greg = 1'b0;
                reg_fields.greg     = 3'b000;
            end
        endcase
    end

    always_comb begin
        reg_fields.has_sreg = 1'b1;
        case (sreg_loc)
            decode_pkg::SREG3_AT_1_5_3: reg_fields.sreg = insn[1][5:3];
            // 2-bit form only reaches es/cs/ss/ds
            decode_pkg::SREG2_AT_1_4_3: reg_fields.sreg = {1'b0, insn[1][4:3]};
            default: begin
                reg_fields.has_sreg = 1'b0;
                reg_fields.sreg     = 3'b000;
            end
        endcase
    end

endmodule

/* src/modrm_extractor.sv */
// mod and r/m selection from the located ModR/M byte
`timescale 1ns/1ps

module modrm_extractor (
    input  decode_pkg::insn_t         insn,
    input  decode_pkg::modrm_loc_e    modrm_loc,
    output decode_pkg::modrm_fields_t modrm
);

    logic [7:0] modrm_byte;

    always_comb begin
        modrm.has_mod_rm = 1'b1;
        case (modrm_loc)
            decode_pkg::MODRM_AT_1: modrm_byte = insn[1];
            decode_pkg::MODRM_AT_2: modrm_byte = insn[2];
            default: begin
                modrm.has_mod_rm = 1'b0;
                modrm_byte       = 8'h00;
            end
        endcase
    end

    // reg/opcode bits 5:3 are handled by the register extractor
    assign modrm.mod = modrm_byte[7:6];
    assign modrm.rm  = modrm_byte[2:0];

endmodule

/* src/decode_control.sv */
// four-phase req/ack FSM with request capture and result registers
`timescale 1ns/1ps

module decode_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  decode_pkg::decode_request_t request,
    output logic                        ack,
    output decode_pkg::decode_request_t captured,
    input  decode_pkg::prefix_flags_t   prefix,
    input  decode_pkg::width_sign_t     width_sign,
    input  decode_pkg::reg_fields_t     reg_fields,
    input  decode_pkg::modrm_fields_t   modrm,
    output decode_pkg::decoded_fields_t result
);

    decode_pkg::dc_state_e state;
    decode_pkg::dc_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            decode_pkg::DC_IDLE: begin
                if (req) begin
                    state_next = decode_pkg::DC_DECODE;
                end
            end
            decode_pkg::DC_DECODE: state_next = decode_pkg::DC_ACK;
            // hold the result until the requester lets go
            decode_pkg::DC_ACK: begin
                if (!req) begin
                    state_next = decode_pkg::DC_IDLE;
                end
            end
            default: state_next = decode_pkg::DC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= decode_pkg::DC_IDLE;
            captured <= '0;
            result   <= '0;
        end else begin
            state <= state_next;
            if (state == decode_pkg::DC_IDLE && req) begin
                captured <= request;
            end
            // extractors settle on captured during the decode cycle
            if (state == decode_pkg::DC_DECODE) begin
                result.width_sign <= width_sign;
                result.reg_fields <= reg_fields;
                result.modrm      <= modrm;
                result.prefix     <= prefix;
            end
        end
    end

    assign ack = (state == decode_pkg::DC_ACK);

endmodule

/* src/decode_field_top.sv */
// decoder top level wiring control, locator and field extractors
`timescale 1ns/1ps

module decode_field_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  decode_pkg::decode_request_t request,
    output logic                        ack,
    output decode_pkg::decoded_fields_t result
);

    decode_pkg::decode_request_t captured;
    decode_pkg::field_loc_t      loc;
    decode_pkg::prefix_flags_t   prefix;
    decode_pkg::width_sign_t     width_sign;
    decode_pkg::reg_fields_t     reg_fields;
    decode_pkg::modrm_fields_t   modrm;

    decode_control u_control (
        .clk(clk), .rst_n(rst_n), .req(req), .request(request), .ack(ack),
        .captured(captured), .prefix(prefix), .width_sign(width_sign),
        .reg_fields(reg_fields), .modrm(modrm), .result(result)
    );

    opcode_locator u_locator (
        .opcode(captured.opcode), .loc(loc), .prefix(prefix)
    );

    width_sign_extractor u_width_sign (
        .insn(captured.insn), .s_at_0_1(loc.s_at_0_1), .w_loc(loc.w_loc),
        .width_sign(width_sign)
    );

    reg_field_extractor u_reg_fields (
        .insn(captured.insn), .greg_loc(loc.greg_loc), .sreg_loc(loc.sreg_loc),
        .reg_fields(reg_fields)
    );

    modrm_extractor u_modrm (
        .insn(captured.insn), .modrm_loc(loc.modrm_loc), .modrm(modrm)
    );

endmodule

/* verification/decode_field_checker.sv */
// decoder result and req/ack handshake checker with error counters
`timescale 1ns/1ps

module decode_field_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic                        ack,
    input  decode_pkg::decoded_fields_t result,
    input  decode_pkg::decoded_fields_t expected,
    output int                          value_errors,
    output int                          handshake_errors,
    output int                          checks_done
);

    logic ack_prev;
    logic req_prev;
    logic pending;
    logic started;
    int   edges;
    decode_pkg::decoded_fields_t held;

    initial begin
        value_errors     = 0;
        handshake_errors = 0;
        checks_done      = 0;
        ack_prev         = 1'b0;
        req_prev         = 1'b0;
        pending          = 1'b0;
        started          = 1'b0;
        edges            = 0;
        held             = '0;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            // idle state straight out of reset
            if (!started) begin
                if (ack !== 1'b0) begin
                    $display("FAIL t=%0t ack expected 0 actual %b", $time, ack);
                    value_errors++;
                end
                if (result !== '0) begin
                    $display("FAIL t=%0t result expected %h actual %h", $time, 20'h0, result);
                    value_errors++;
                end
            end
            if (req && !ack && !pending) begin
                pending = 1'b1;
                started = 1'b1;
                edges   = 0;
            end else if (pending) begin
                edges++;
                // ack should first be seen high at the second edge after req
                if (ack) begin
                    pending = 1'b0;
                    checks_done++;
                    if (edges != 2) begin
                        $display("ack rose %0d edges after req was sampled, not 2 (t=%0t)",
                                 edges, $time);
                        handshake_errors++;
                    end
                    if (result !== expected) begin
                        $display("FAIL t=%0t result expected %h actual %h",
                                 $time, expected, result);
                        value_errors++;
                    end
                    held = result;
                end
            end else if (ack) begin
                if (!ack_prev) begin
                    $display("ack rose with no request pending (t=%0t)", $time);
                    handshake_errors++;
                end else if (result !== held) begin
                    $display("FAIL t=%0t result expected %h actual %h", $time, held, result);
                    value_errors++;
                end
            end
            if (ack_prev && req_prev && !ack) begin
                $display("ack fell while req was still high (t=%0t)", $time);
                handshake_errors++;
            end
            ack_prev = ack;
            req_prev = req;
        end
    end

endmodule

/* verification/decode_field_tb.sv */
// decoder testbench with clock, reset, vector file stimulus over req/ack and result summary
`timescale 1ns/1ps

module decode_field_tb;

    localparam int num_vectors = 22;
    localparam int hold_index  = 4;
    localparam int hold_cycles = 6;
    localparam int ack_timeout = 50;
    localparam int drive_delay = 2;

    logic                        clk;
    logic                        rst_n;
    logic                        req;
    logic                        ack;
    decode_pkg::decode_request_t request;
    decode_pkg::decoded_fields_t result;
    decode_pkg::decoded_fields_t expected;

    // opcode byte, three instruction bytes, expected fields
    logic [51:0] vectors [0:num_vectors-1];

    int value_errors;
    int handshake_errors;
    int checks_done;
    int timeout_errors;
    int other_errors;
    int total_errors;
    logic run_ok;

    decode_field_top uut (
        .clk(clk), .rst_n(rst_n), .req(req), .request(request), .ack(ack), .result(result)
    );

    decode_field_checker u_checker (
        .clk(clk), .rst_n(rst_n), .req(req), .ack(ack), .result(result),
        .expected(expected), .value_errors(value_errors),
        .handshake_errors(handshake_errors), .checks_done(checks_done)
    );

    always #20 clk = ~clk;

    task automatic wait_for_ack(input logic level, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < ack_timeout) begin
            @(posedge clk);
            #(drive_delay);
            if (ack === level) begin
                seen = 1'b1;
            end
            n++;
        end
    endtask

    task automatic run_request(input logic [51:0] vec, input int hold, output logic ok);
        logic seen;
        ok = 1'b1;
        request.opcode = decode_pkg::op_e'(vec[48:44]);
        request.insn   = vec[43:20];
        expected       = vec[19:0];
        req            = 1'b1;
        wait_for_ack(1'b1, seen);
        if (!seen) begin
            $display("timeout waiting for ack to rise, opcode %0d", vec[48:44]);
            timeout_errors++;
            ok = 1'b0;
        end else begin
            // requester stalls with req high to test back-pressure
            if (hold > 0) begin
                repeat (hold) @(posedge clk);
                #(drive_delay);
            end
            req = 1'b0;
            wait_for_ack(1'b0, seen);
            if (!seen) begin
                $display("timeout waiting for ack to fall, opcode %0d", vec[48:44]);
                timeout_errors++;
                ok = 1'b0;
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = 1'b0;
        request        = '0;
        expected       = '0;
        timeout_errors = 0;
        other_errors   = 0;
        run_ok         = 1'b1;
        $readmemh("verification/decode_field_vectors.hex", vectors);
        repeat (10) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;
        repeat (3) @(posedge clk);
        #(drive_delay);
        for (int i = 0; i < num_vectors && run_ok; i++) begin
            if ($isunknown(vectors[i])) begin
                $display("vector %0d is missing or unreadable in the vector file", i);
                other_errors++;
                run_ok = 1'b0;
            end else begin
                run_request(vectors[i], (i == hold_index) ? hold_cycles : 0, run_ok);
            end
        end
        repeat (2) @(posedge clk);
        if (checks_done != num_vectors) begin
            $display("only %0d of %0d results were checked", checks_done, num_vectors);
            other_errors++;
        end
        total_errors = value_errors + handshake_errors + timeout_errors + other_errors;
        $display("errors: value=%0d handshake=%0d timeout=%0d other=%0d total=%0d",
                 value_errors, handshake_errors, timeout_errors, other_errors, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/decode_field_vectors.hex */
// columns: opcode code (2 digits), bytes 0 1 2 (6 digits), expected decoded_fields_t (5 digits)
// fields: {has_s s has_w w} {has_greg greg has_sreg sreg} {has_mod_rm mod rm} {is_prefix is_prefix_seg}
0583C305F00EC // add imm s=1 w=1
0581C178B00E4 // add imm s=0 w=1
02B9341239000 // mov imm short w=1
02B1560029000 // mov imm short w=0
040FBFC8390E0 // movsx w=1 (held req)
040FBEC8290E0 // movsx w=0
1390000000000 // nop
095300000B000 // push reg short
0189D8003B0E0 // mov reg to rm
0B0FA3D10A0E4 // bt rm with reg
0D0F22C30B000 // mov cr from reg
038EE00000CE0 // mov rm to sreg, 3-bit
0A1E3E0000B00 // push sreg, 2-bit
07F7160030098 // not rm
0C0F9445000B4 // sete
102E000000003 // cs override
1164000000003 // fs override
0E66000000002 // operand size prefix
0FF0000000002 // lock prefix
128D4508000B4 // lea
066BC005C00E0 // imul rm imm
084700000F000 // inc reg

/* sim.f */
src/decode_pkg.sv
src/opcode_locator.sv
src/width_sign_extractor.sv
src/reg_field_extractor.sv
src/modrm_extractor.sv
src/decode_control.sv
src/decode_field_top.sv
verification/decode_field_checker.sv
verification/decode_field_tb.sv
